//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_buffer_manager
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SRCS    := $(shell grep -v '^+' $(FILELIST))
HDRS    := $(wildcard sim/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q '\*\*\* TEST FAILED \*\*\*' $(LOG) || \
	    ! grep -q '\*\*\* TEST PASSED \*\*\*' $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- all.f
+incdir+sim
design/bm_pkg.sv
design/dpram.sv
design/bm_ctrl.sv
design/fm_pingpong.sv
design/filter_packer.sv
design/filter_store.sv
design/buffer_manager.sv
sim/tb_buffer_manager.sv

//--- design/bm_ctrl.sv
`timescale 1ns/1ps

module bm_ctrl (
    input  logic             clk,
    input  logic             rstn,
    input  logic             load_ifm,
    input  logic             load_filter,
    input  logic             csync_run,
    input  logic             fm_buf_switch,
    input  logic             stream_vld,
    input  logic             filter_last_wr,
    output logic             ifm_load_start,
    output logic             ifm_load_en,
    output logic             filter_first,
    output logic             filter_en,
    output bm_pkg::fm_role_e role0,
    output logic             fb_ready,
    output logic             csync_done
);
    import bm_pkg::*;

    load_state_e state, state_nxt;
    logic        load_ifm_d, load_filter_d, csync_run_d;
    logic        ifm_rise, filter_rise, csync_rise;

    // --------------------------------------------------
    // request edge detection
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            load_ifm_d    <= 1'b0;
            load_filter_d <= 1'b0;
            csync_run_d   <= 1'b0;
        end else begin
            load_ifm_d    <= load_ifm;
            load_filter_d <= load_filter;
            csync_run_d   <= csync_run;
        end
    end

    assign ifm_rise    = load_ifm & ~load_ifm_d;
    assign filter_rise = load_filter & ~load_filter_d;
    assign csync_rise  = csync_run & ~csync_run_d;

    // --------------------------------------------------
    // load fsm
    always_comb begin
        state_nxt = state;
        if (ifm_rise) begin
            state_nxt = LD_IFM;
        end else if (filter_rise) begin
            state_nxt = LD_FILTER_ARMED;
        end else begin
            case (state)
                LD_IFM:          if (!load_ifm) state_nxt = LD_IDLE;
                LD_FILTER_ARMED: begin
                    if (!load_filter) begin
                        state_nxt = LD_IDLE;
                    end else if (stream_vld) begin
                        state_nxt = LD_FILTER;   // first beat of the kernel set
                    end
                end
                LD_FILTER:       if (!load_filter) state_nxt = LD_IDLE;
                default:         state_nxt = LD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= LD_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    assign ifm_load_start = ifm_rise;
    assign ifm_load_en    = load_ifm & (ifm_rise | (state == LD_IFM));
    assign filter_first   = load_filter & stream_vld & (state == LD_FILTER_ARMED);
    assign filter_en      = load_filter & ((state == LD_FILTER_ARMED) | (state == LD_FILTER));

    // --------------------------------------------------
    // bank role pointer and filter ready flag
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            role0    <= ROLE_IFM;
            fb_ready <= 1'b0;
        end else begin
            if (fm_buf_switch) begin
                role0 <= (role0 == ROLE_IFM) ? ROLE_OFM : ROLE_IFM;
            end
            if (csync_rise || filter_rise) begin
                fb_ready <= 1'b0;   // new sync or new kernel set
            end else if (filter_last_wr) begin
                fb_ready <= 1'b1;
            end
        end
    end

    assign csync_done = csync_run & fb_ready;

    // ifm and filter loads share the stream
    a_one_load: assert property (@(posedge clk) disable iff (!rstn)
        !(load_ifm && load_filter));

endmodule

//--- design/bm_pkg.sv
package bm_pkg;

    // stream and buffer geometry, depths cut down for sim
    localparam int STREAM_DW    = 32;
    localparam int FM_AW        = 10;   // 1024 words per bank
    localparam int FM_DW        = 32;
    localparam int FILTER_AW    = 7;
    localparam int FILTER_DW    = 72;   // nine 8-bit taps
    localparam int FILTER_LANES = 4;
    localparam int KERNEL_TAPS  = 9;
    localparam int W_SIZE       = 5;
    localparam int W_CHANNEL    = 5;

    typedef struct packed {
        logic [W_SIZE-1:0]    width;
        logic [W_SIZE-1:0]    height;
        logic [W_CHANNEL-1:0] channel;
        logic [W_CHANNEL-1:0] channel_out;
    } layer_cfg_t;

    // axi side read stream, no back-pressure
    typedef struct packed {
        logic                 vld;
        logic [STREAM_DW-1:0] data;
    } stream_t;

    typedef struct packed {
        logic             vld;
        logic [FM_AW-1:0] addr;
        logic [FM_DW-1:0] data;
    } ofm_wr_t;

    typedef struct packed {
        logic             req;
        logic [FM_AW-1:0] addr;
    } fm_rd_t;

    typedef struct packed {
        logic                 req;
        logic [FILTER_AW-1:0] addr;
    } fb_rd_t;

    typedef logic [FILTER_LANES-1:0][FILTER_DW-1:0] fb_data_t;

    typedef enum logic {ROLE_IFM = 1'b0, ROLE_OFM = 1'b1} fm_role_e;

    typedef enum logic [1:0] {
        LD_IDLE,
        LD_IFM,
        LD_FILTER_ARMED,
        LD_FILTER
    } load_state_e;

endpackage

//--- design/buffer_manager.sv
`timescale 1ns/1ps

module buffer_manager (
    input  logic               clk,
    input  logic               rstn,
    input  bm_pkg::layer_cfg_t cfg,
    input  logic               load_ifm,
    input  logic               load_filter,
    input  logic               fm_buf_switch,
    input  logic               csync_run,
    input  bm_pkg::stream_t    stream,
    input  bm_pkg::ofm_wr_t    ofm_wr,
    input  bm_pkg::fm_rd_t     ifm_rd,
    input  bm_pkg::fb_rd_t     fb_rd,
    output logic [bm_pkg::FM_DW-1:0] ifm_data,
    output bm_pkg::fb_data_t   fb_data,
    output logic               fb_ready,
    output logic               csync_done,
    output logic               ofm_done
);
    import bm_pkg::*;

    logic     ifm_load_start, ifm_load_en;
    logic     filter_first, filter_en;
    logic     filter_last_wr;
    logic     commit;
    fm_role_e role0;
    fb_data_t lane_words;

    bm_ctrl u_ctrl (
        .clk            (clk),
        .rstn           (rstn),
        .load_ifm       (load_ifm),
        .load_filter    (load_filter),
        .csync_run      (csync_run),
        .fm_buf_switch  (fm_buf_switch),
        .stream_vld     (stream.vld),
        .filter_last_wr (filter_last_wr),
        .ifm_load_start (ifm_load_start),
        .ifm_load_en    (ifm_load_en),
        .filter_first   (filter_first),
        .filter_en      (filter_en),
        .role0          (role0),
        .fb_ready       (fb_ready),
        .csync_done     (csync_done)
    );

    fm_pingpong u_fm (
        .clk            (clk),
        .rstn           (rstn),
        .cfg            (cfg),
        .stream         (stream),
        .ifm_load_start (ifm_load_start),
        .ifm_load_en    (ifm_load_en),
        .role0          (role0),
        .ofm_wr         (ofm_wr),
        .ifm_rd         (ifm_rd),
        .ifm_data       (ifm_data),
        .ofm_done       (ofm_done)
    );

    filter_packer u_packer (
        .clk          (clk),
        .rstn         (rstn),
        .stream       (stream),
        .filter_first (filter_first),
        .filter_en    (filter_en),
        .commit       (commit),
        .lane_words   (lane_words)
    );

    filter_store u_filter (
        .clk            (clk),
        .rstn           (rstn),
        .cfg            (cfg),
        .filter_first   (filter_first),
        .commit         (commit),
        .lane_words     (lane_words),
        .fb_rd          (fb_rd),
        .fb_data        (fb_data),
        .filter_last_wr (filter_last_wr)
    );

endmodule

//--- design/dpram.sv
`timescale 1ns/1ps

module dpram #(
    parameter int AW = 10,
    parameter int DW = 32
) (
    input  logic          clk,
    input  logic          rstn,
    input  logic          wr_en,
    input  logic [AW-1:0] wr_addr,
    input  logic [DW-1:0] wr_data,
    input  logic          rd_en,
    input  logic [AW-1:0] rd_addr,
    output logic [DW-1:0] rd_data
);

    logic [DW-1:0] mem [0:(1<<AW)-1];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, holds last word when idle
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rd_data <= '0;
        end else if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

//--- design/filter_packer.sv
`timescale 1ns/1ps

module filter_packer (
    input  logic             clk,
    input  logic             rstn,
    input  bm_pkg::stream_t  stream,
    input  logic             filter_first,
    input  logic             filter_en,
    output logic             commit,
    output bm_pkg::fb_data_t lane_words
);
    import bm_pkg::*;

    logic [3:0] tap;        // kernel position of the next beat
    logic [3:0] tap_use;
    logic       beat_vld;
    logic       group_end;

    assign beat_vld  = filter_en & stream.vld;
    assign tap_use   = filter_first ? 4'd0 : tap;
    assign group_end = beat_vld && (tap_use == 4'(KERNEL_TAPS - 1));

    // --------------------------------------------------
    // tap counter and commit
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            tap    <= '0;
            commit <= 1'b0;
        end else begin
            commit <= group_end;   // accumulators complete next cycle
            if (beat_vld) begin
                tap <= group_end ? 4'd0 : tap_use + 4'd1;
            end
        end
    end

    // byte j of the beat goes to lane j, at byte slot tap
    always_ff @(posedge clk) begin
        if (beat_vld) begin
            for (int j = 0; j < FILTER_LANES; j++) begin
                if (tap_use == 4'd0) begin
                    lane_words[j] <= '0;
                end
                lane_words[j][8*tap_use +: 8] <= stream.data[8*j +: 8];
            end
        end
    end

    a_tap_range: assert property (@(posedge clk) disable iff (!rstn)
        tap <= 4'(KERNEL_TAPS - 1));

endmodule

//--- design/filter_store.sv
`timescale 1ns/1ps

module filter_store (
    input  logic               clk,
    input  logic               rstn,
    input  bm_pkg::layer_cfg_t cfg,
    input  logic               filter_first,
    input  logic               commit,
    input  bm_pkg::fb_data_t   lane_words,
    input  bm_pkg::fb_rd_t     fb_rd,
    output wire bm_pkg::fb_data_t fb_data,
    output logic               filter_last_wr
);
    import bm_pkg::*;

    logic [FILTER_AW-1:0] wr_addr;
    logic [FILTER_AW-1:0] fb_last_addr;

    assign fb_last_addr = (FILTER_AW'(cfg.channel) << 2) - FILTER_AW'(1);   // channel*4 - 1

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_addr <= '0;
        end else if (filter_first) begin
            wr_addr <= '0;
        end else if (commit) begin
            wr_addr <= (wr_addr == fb_last_addr) ? '0 : wr_addr + 1'b1;
        end
    end

    assign filter_last_wr = commit && (wr_addr == fb_last_addr);

    // one ram per filter lane, shared addressing
    for (genvar j = 0; j < FILTER_LANES; j++) begin : g_lane
        dpram #(.AW(FILTER_AW), .DW(FILTER_DW)) u_filter_buf (
            .clk     (clk),
            .rstn    (rstn),
            .wr_en   (commit),
            .wr_addr (wr_addr),
            .wr_data (lane_words[j]),
            .rd_en   (fb_rd.req),
            .rd_addr (fb_rd.addr),
            .rd_data (fb_data[j])
        );
    end

endmodule

//--- design/fm_pingpong.sv
`timescale 1ns/1ps

module fm_pingpong (
    input  logic               clk,
    input  logic               rstn,
    input  bm_pkg::layer_cfg_t cfg,
    input  bm_pkg::stream_t    stream,
    input  logic               ifm_load_start,
    input  logic               ifm_load_en,
    input  bm_pkg::fm_role_e   role0,
    input  bm_pkg::ofm_wr_t    ofm_wr,
    input  bm_pkg::fm_rd_t     ifm_rd,
    output logic [bm_pkg::FM_DW-1:0] ifm_data,
    output logic               ofm_done
);
    import bm_pkg::*;

    fm_role_e         role1;
    fm_role_e         rd_role0;     // role at the time of the read
    logic             ld_active;
    logic             ld_wr_en;
    logic [FM_AW-1:0] ld_wr_addr;
    logic [FM_DW-1:0] ld_wr_data;
    logic             buf0_wr_en, buf1_wr_en;
    logic [FM_AW-1:0] buf0_wr_addr;
    logic [FM_DW-1:0] buf0_wr_data;
    logic             buf0_rd_en, buf1_rd_en;
    logic [FM_DW-1:0] buf0_rd_data, buf1_rd_data;
    logic [FM_AW-1:0] ofm_last_addr;

    assign role1 = (role0 == ROLE_IFM) ? ROLE_OFM : ROLE_IFM;

    // --------------------------------------------------
    // ifm load path, one cycle behind the stream
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ld_active  <= 1'b0;
            ld_wr_en   <= 1'b0;
            ld_wr_addr <= '0;
        end else begin
            ld_active <= ifm_load_en;
            ld_wr_en  <= ifm_load_en & stream.vld;
            if (ifm_load_start) begin
                ld_wr_addr <= '0;
            end else if (ld_wr_en) begin
                ld_wr_addr <= ld_wr_addr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        ld_wr_data <= stream.data;
    end

    // --------------------------------------------------
    // write and read steering, load always lands in bank 0
    assign buf0_wr_en   = ld_active ? ld_wr_en : (ofm_wr.vld && role0 == ROLE_OFM);
    assign buf0_wr_addr = ld_active ? ld_wr_addr : ofm_wr.addr;
    assign buf0_wr_data = ld_active ? ld_wr_data : ofm_wr.data;
    assign buf1_wr_en   = ofm_wr.vld && (role1 == ROLE_OFM);

    assign buf0_rd_en = ifm_rd.req && (role0 == ROLE_IFM);
    assign buf1_rd_en = ifm_rd.req && (role1 == ROLE_IFM);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rd_role0 <= ROLE_IFM;
        end else begin
            rd_role0 <= role0;
        end
    end

    assign ifm_data = (rd_role0 == ROLE_IFM) ? buf0_rd_data : buf1_rd_data;

    dpram #(.AW(FM_AW), .DW(FM_DW)) u_fm_buf0 (
        .clk     (clk),
        .rstn    (rstn),
        .wr_en   (buf0_wr_en),
        .wr_addr (buf0_wr_addr),
        .wr_data (buf0_wr_data),
        .rd_en   (buf0_rd_en),
        .rd_addr (ifm_rd.addr),
        .rd_data (buf0_rd_data)
    );

    // spare bank for ping-pong
    dpram #(.AW(FM_AW), .DW(FM_DW)) u_fm_buf1 (
        .clk     (clk),
        .rstn    (rstn),
        .wr_en   (buf1_wr_en),
        .wr_addr (ofm_wr.addr),
        .wr_data (ofm_wr.data),
        .rd_en   (buf1_rd_en),
        .rd_addr (ifm_rd.addr),
        .rd_data (buf1_rd_data)
    );

    // --------------------------------------------------
    // last ofm word of the layer
    assign ofm_last_addr = FM_AW'(cfg.width) * FM_AW'(cfg.height) * FM_AW'(cfg.channel_out)
                         - FM_AW'(1);
    assign ofm_done      = ofm_wr.vld && (ofm_wr.addr == ofm_last_addr);

    a_ofm_in_range: assert property (@(posedge clk) disable iff (!rstn)
        ofm_wr.vld |-> ofm_wr.addr <= ofm_last_addr);

endmodule

//--- sim/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// reference banks, indexed by physical bank number
logic [FM_DW-1:0] fm_ref [2][1<<FM_AW];
fb_data_t         fb_ref [1<<FILTER_AW];
fm_role_e         role0_m   = ROLE_IFM;   // mirror of the bank 0 role
int               fm_errs   = 0;
int               fb_errs   = 0;
int               flag_errs = 0;

// last output word of the layer, no pooling or upsampling
function automatic int fm_last_addr(input layer_cfg_t c);
    return int'(c.width) * int'(c.height) * int'(c.channel_out) - 1;
endfunction

function automatic int ifm_bank();
    return (role0_m == ROLE_IFM) ? 0 : 1;
endfunction

function automatic int ofm_bank();
    return (role0_m == ROLE_OFM) ? 0 : 1;
endfunction

// byte j of a beat goes to byte slot tap of lane j
function automatic fb_data_t pack_tap(input fb_data_t acc, input int tap,
                                      input logic [STREAM_DW-1:0] beat);
    fb_data_t w;
    w = acc;
    for (int j = 0; j < FILTER_LANES; j++) begin
        w[j][8*tap +: 8] = beat[8*j +: 8];
    end
    return w;
endfunction

// --------------------------------------------------
// compare tasks
task automatic check_fm(input logic [FM_DW-1:0] got, input logic [FM_DW-1:0] exp,
                        input string what);
    if (got !== exp) begin
        fm_errs++;
        $display("ERROR @%0t: %s got %h expected %h", $time, what, got, exp);
    end
endtask

task automatic check_filter(input fb_data_t got, input fb_data_t exp, input string what);
    if (got !== exp) begin
        fb_errs++;
        $display("ERROR @%0t: %s got %h expected %h", $time, what, got, exp);
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        flag_errs++;
        $display("ERROR @%0t: %s is %b, expected %b", $time, name, got, exp);
    end
endtask

`endif

//--- sim/tb_buffer_manager.sv
`timescale 1ns/1ps

module tb_buffer_manager;
    import bm_pkg::*;

    logic             clk = 1'b0;
    logic             rstn;
    layer_cfg_t       cfg;
    logic             load_ifm, load_filter, fm_buf_switch, csync_run;
    stream_t          stream;
    ofm_wr_t          ofm_wr;
    fm_rd_t           ifm_rd;
    fb_rd_t           fb_rd;
    logic [FM_DW-1:0] ifm_data;
    fb_data_t         fb_data;
    logic             fb_ready, csync_done, ofm_done;

    integer           seed = 31385;
    int               cycle_cnt = 0;
    int               cycle_limit = 100000;   // replaced once cfg is known
    int               n_ifm, n_ofm, n_groups;
    logic [FM_DW-1:0] ifm_rd_exp;
    fb_data_t         fb_rd_exp;

    `include "tb_model.svh"

    buffer_manager dut (
        .clk           (clk),
        .rstn          (rstn),
        .cfg           (cfg),
        .load_ifm      (load_ifm),
        .load_filter   (load_filter),
        .fm_buf_switch (fm_buf_switch),
        .csync_run     (csync_run),
        .stream        (stream),
        .ofm_wr        (ofm_wr),
        .ifm_rd        (ifm_rd),
        .fb_rd         (fb_rd),
        .ifm_data      (ifm_data),
        .fb_data       (fb_data),
        .fb_ready      (fb_ready),
        .csync_done    (csync_done),
        .ofm_done      (ofm_done)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout: run exceeded %0d cycles", cycle_limit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // --------------------------------------------------
    // one clock; checks the reads issued last cycle, returns at edge + 2 ns
    task automatic next_cycle();
        @(posedge clk);
        #1;
        if (ifm_rd.req) begin
            check_fm(ifm_data, ifm_rd_exp, "ifm read");
        end
        if (fb_rd.req) begin
            check_filter(fb_data, fb_rd_exp, "filter read");
        end
        #1;
    endtask

    task automatic stream_gap();
        if (($random(seed) & 3) == 0) begin
            stream.vld = 1'b0;
            next_cycle();
        end
    endtask

    task automatic load_ifm_stream();
        logic [STREAM_DW-1:0] beat;
        load_ifm = 1'b1;
        next_cycle();
        for (int i = 0; i < n_ifm; i++) begin
            stream_gap();
            beat        = $random(seed);
            stream.vld  = 1'b1;
            stream.data = beat;
            fm_ref[0][i] = beat;   // loads always land in bank 0
            next_cycle();
        end
        stream.vld = 1'b0;
        load_ifm   = 1'b0;
        repeat (3) next_cycle();
    endtask

    task automatic read_fm(input int count);
        for (int a = 0; a < count; a++) begin
            next_cycle();
            ifm_rd.req  = 1'b1;
            ifm_rd.addr = FM_AW'(a);
            ifm_rd_exp  = fm_ref[ifm_bank()][a];
        end
        next_cycle();
        ifm_rd.req = 1'b0;
    endtask

    task automatic load_filter_stream();
        fb_data_t             acc;
        logic [STREAM_DW-1:0] beat;
        load_filter = 1'b1;
        next_cycle();
        for (int g = 0; g < n_groups; g++) begin
            acc = '0;
            for (int k = 0; k < KERNEL_TAPS; k++) begin
                stream_gap();
                beat        = $random(seed);
                stream.vld  = 1'b1;
                stream.data = beat;
                acc         = pack_tap(acc, k, beat);
                next_cycle();
                check_flag("fb_ready during load", fb_ready, 1'b0);
            end
            fb_ref[g] = acc;
        end
        stream.vld  = 1'b0;
        load_filter = 1'b0;
        while (fb_ready !== 1'b1) begin
            next_cycle();
        end
    endtask

    task automatic read_filter();
        for (int a = 0; a < n_groups; a++) begin
            next_cycle();
            fb_rd.req  = 1'b1;
            fb_rd.addr = FILTER_AW'(a);
            fb_rd_exp  = fb_ref[a];
        end
        next_cycle();
        fb_rd.req = 1'b0;
    endtask

    task automatic csync_check();
        check_flag("csync_done with run low", csync_done, 1'b0);
        csync_run = 1'b1;
        #1;
        check_flag("csync_done with run high", csync_done, 1'b1);
        next_cycle();
        check_flag("fb_ready after csync edge", fb_ready, 1'b0);
        check_flag("csync_done after csync edge", csync_done, 1'b0);
        csync_run = 1'b0;
        next_cycle();
    endtask

    task automatic write_ofm();
        int               last;
        int               bank;
        int               a;
        logic [FM_DW-1:0] data;
        last = fm_last_addr(cfg);
        bank = ofm_bank();
        // 16 random addresses, then a full sweep
        for (int i = 0; i < n_ofm + 16; i++) begin
            if (($random(seed) & 3) == 0) begin
                ofm_wr.vld = 1'b0;
                #1;
                check_flag("ofm_done while idle", ofm_done, 1'b0);
                next_cycle();
            end
            a    = (i < 16) ? int'($unsigned($random(seed)) % n_ofm) : i - 16;
            data = $random(seed);
            ofm_wr.vld   = 1'b1;
            ofm_wr.addr  = FM_AW'(a);
            ofm_wr.data  = data;
            fm_ref[bank][a] = data;
            #1;
            check_flag("ofm_done", ofm_done, a == last);
            next_cycle();
        end
        ofm_wr.vld = 1'b0;
        next_cycle();
    endtask

    task automatic switch_banks();
        fm_buf_switch = 1'b1;
        next_cycle();
        fm_buf_switch = 1'b0;
        role0_m = (role0_m == ROLE_IFM) ? ROLE_OFM : ROLE_IFM;
        next_cycle();
    endtask

    // --------------------------------------------------
    initial begin
        rstn          = 1'b0;
        cfg           = '0;
        load_ifm      = 1'b0;
        load_filter   = 1'b0;
        fm_buf_switch = 1'b0;
        csync_run     = 1'b0;
        stream        = '0;
        ofm_wr        = '0;
        ifm_rd        = '0;
        fb_rd         = '0;

        cfg.width       = W_SIZE'(1 + ($random(seed) & 7));
        cfg.height      = W_SIZE'(1 + ($random(seed) & 7));
        cfg.channel     = W_CHANNEL'(1 + ($random(seed) & 7));
        cfg.channel_out = W_CHANNEL'(1 + ($random(seed) & 7));
        n_ifm    = 64 + ($random(seed) & 127);
        n_ofm    = fm_last_addr(cfg) + 1;
        n_groups = int'(cfg.channel) * FILTER_LANES;
        // gaps at most double a load, reads one cycle each
        cycle_limit = 2 * (4 * n_ifm + 19 * n_groups + 3 * n_ofm + 80) + 200;

        repeat (5) @(posedge clk);
        #2;
        rstn = 1'b1;
        next_cycle();
        check_flag("fb_ready after reset", fb_ready, 1'b0);
        check_flag("csync_done after reset", csync_done, 1'b0);
        check_flag("ofm_done after reset", ofm_done, 1'b0);
        check_fm(ifm_data, '0, "ifm_data after reset");
        check_filter(fb_data, '0, "fb_data after reset");

        load_ifm_stream();
        read_fm(n_ifm);
        load_filter_stream();
        csync_check();
        read_filter();
        write_ofm();
        switch_banks();
        read_fm(n_ofm);
        switch_banks();
        read_fm(n_ifm);
        repeat (2) next_cycle();

        $display("errors: fm %0d, filter %0d, flag %0d", fm_errs, fb_errs, flag_errs);
        if (fm_errs + fb_errs + flag_errs == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
